/* design/alu_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared constants for the ALU coprocessor: bus map, command codes,
// flag positions and queue sizing. Imported by every RTL module.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package alu_pkg;

  // bus data and operand width.
  localparam int data_width  = 16;
  // results queued or in flight at once.
  localparam int queue_depth = 4;
  localparam int count_width = $clog2(queue_depth + 1);
  localparam int ptr_width   = $clog2(queue_depth);

  // word addresses of the register map.
  localparam logic [2:0] reg_x      = 3'd0;
  localparam logic [2:0] reg_y      = 3'd1;
  localparam logic [2:0] reg_iflags = 3'd2;
  localparam logic [2:0] reg_cmd    = 3'd3;
  localparam logic [2:0] reg_result = 3'd4;
  localparam logic [2:0] reg_oflags = 3'd5;
  localparam logic [2:0] reg_status = 3'd6;

  // op class, cmd bits 1:0.
  localparam logic [1:0] class_arith = 2'd0;
  localparam logic [1:0] class_shift = 2'd1;
  localparam logic [1:0] class_move  = 2'd2;

  // group-1 func codes, cmd bits 4:2.
  localparam logic [2:0] func_add = 3'd0;
  localparam logic [2:0] func_or  = 3'd1;
  localparam logic [2:0] func_adc = 3'd2;
  localparam logic [2:0] func_sbb = 3'd3;
  localparam logic [2:0] func_and = 3'd4;
  localparam logic [2:0] func_sub = 3'd5;
  localparam logic [2:0] func_xor = 3'd6;
  localparam logic [2:0] func_cmp = 3'd7;

  // shift group func codes.
  localparam logic [2:0] func_rol = 3'd0;
  localparam logic [2:0] func_ror = 3'd1;
  localparam logic [2:0] func_rcl = 3'd2;
  localparam logic [2:0] func_rcr = 3'd3;
  localparam logic [2:0] func_shl = 3'd4;
  localparam logic [2:0] func_shr = 3'd5;
  localparam logic [2:0] func_sal = 3'd6;
  localparam logic [2:0] func_sar = 3'd7;

  // x86 status flag positions in the flag word.
  localparam int flag_cf = 0;
  localparam int flag_pf = 2;
  localparam int flag_af = 4;
  localparam int flag_zf = 6;
  localparam int flag_sf = 7;
  localparam int flag_of = 11;

endpackage

/* design/alu_wb_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone classic slave: operand registers, command issue, credit
// tracking and result queue read-back.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module alu_wb_regs import alu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cyc,
  input  logic                   stb,
  input  logic                   we,
  input  logic [2:0]             adr,
  input  logic [data_width-1:0]  dat_w,
  input  logic [data_width-1:0]  q_head_result,
  input  logic [data_width-1:0]  q_head_flags,
  input  logic [count_width-1:0] q_count,
  input  logic                   q_push,
  output logic                   ack,
  output logic [data_width-1:0]  dat_r,
  output logic                   issue,
  output logic [data_width-1:0]  x,
  output logic [data_width-1:0]  y,
  output logic [data_width-1:0]  iflags,
  output logic [1:0]             op_class,
  output logic [2:0]             func,
  output logic                   word_op,
  output logic                   q_pop
);

  logic                   req;
  logic                   cmd_wr;
  logic                   stall;
  logic                   q_empty;
  logic [count_width-1:0] credit;

  // new transfer, not yet acked.
  assign req     = cyc && stb && !ack;
  assign cmd_wr  = we && (adr == reg_cmd);
  // cmd waits while every queue slot is spoken for.
  assign stall   = cmd_wr && (credit == count_width'(queue_depth));
  assign q_empty = (q_count == '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack   <= 1'b0;
      issue <= 1'b0;
      q_pop <= 1'b0;
    end else begin
      ack   <= req && !stall;
      // issue pulse lines up with the ack cycle.
      issue <= req && !stall && cmd_wr;
      // oflags read pops the head, never on empty.
      q_pop <= req && !we && (adr == reg_oflags) && !q_empty;
    end
  end

  // credit counts entries in flight plus queued.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credit <= '0;
    end else begin
      case ({issue, q_pop})
        2'b10:   credit <= credit + 1'b1;
        2'b01:   credit <= credit - 1'b1;
        default: credit <= credit;
      endcase
    end
  end

  // operand and command registers.
  always_ff @(posedge clk) begin
    if (req && we) begin
      case (adr)
        reg_x:      x <= dat_w;
        reg_y:      y <= dat_w;
        reg_iflags: iflags <= dat_w;
        default: ;
      endcase
    end
    if (req && !stall && cmd_wr) begin
      op_class <= dat_w[1:0];
      func     <= dat_w[4:2];
      word_op  <= dat_w[5];
    end
  end

  // read data, sampled with the request.
  always_ff @(posedge clk) begin
    if (req && !we) begin
      case (adr)
        reg_x:      dat_r <= x;
        reg_y:      dat_r <= y;
        reg_iflags: dat_r <= iflags;
        reg_cmd:    dat_r <= {10'd0, word_op, func, op_class};
        reg_result: dat_r <= q_empty ? '0 : q_head_result;
        reg_oflags: dat_r <= q_empty ? '0 : q_head_flags;
        reg_status: dat_r <= data_width'(q_count);
        default:    dat_r <= '0;
      endcase
    end
  end

  a_ack_in_stb: assert property (@(posedge clk) disable iff (!rst_n) ack |-> stb);
  a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
    credit <= count_width'(queue_depth));
  // every queued or incoming entry holds a credit.
  a_credit_cover: assert property (@(posedge clk) disable iff (!rst_n)
    credit >= q_count + count_width'(q_push));

endmodule

/* design/alu_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode stage: captures an issued command and masks the operands to
// the working width before execute.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module alu_decode import alu_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  issue,
  input  logic [data_width-1:0] x,
  input  logic [data_width-1:0] y,
  input  logic [data_width-1:0] iflags,
  input  logic [1:0]            op_class,
  input  logic [2:0]            func,
  input  logic                  word_op,
  output logic                  d_valid,
  output logic [data_width-1:0] d_x,
  output logic [data_width-1:0] d_y,
  output logic [data_width-1:0] d_iflags,
  output logic [1:0]            d_class,
  output logic [2:0]            d_func,
  output logic                  d_word_op
);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      d_valid <= 1'b0;
    end else begin
      d_valid <= issue;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      // byte ops see only the low byte.
      d_x <= word_op ? x : {8'd0, x[7:0]};
      if (op_class == class_shift) begin
        // count is taken mod 32, as on x86.
        d_y <= {11'd0, y[4:0]};
      end else begin
        d_y <= word_op ? y : {8'd0, y[7:0]};
      end
      d_iflags  <= iflags;
      d_class   <= op_class;
      d_func    <= func;
      d_word_op <= word_op;
    end
  end

endmodule

/* design/alu_execute.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage: group-1 arithmetic and logic, shifts and rotates, move.
// Produces the result with raw cf, af and of for the flags stage.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module alu_execute import alu_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  d_valid,
  input  logic [data_width-1:0] d_x,
  input  logic [data_width-1:0] d_y,
  input  logic [data_width-1:0] d_iflags,
  input  logic [1:0]            d_class,
  input  logic [2:0]            d_func,
  input  logic                  d_word_op,
  output logic                  e_valid,
  output logic [data_width-1:0] e_result,
  output logic                  e_cf,
  output logic                  e_af,
  output logic                  e_of,
  output logic                  e_keep,
  output logic                  e_word_op,
  output logic [data_width-1:0] e_iflags
);

  logic [data_width-1:0] n_result;
  logic                  n_cf;
  logic                  n_af;
  logic                  n_of;
  logic                  n_keep;

  always_comb begin : exec_comb
    logic [data_width:0]   sum;
    logic                  cin;
    logic                  sub_op;
    logic [3:0]            msb;
    logic                  xm;
    logic                  ym;
    logic                  rm;
    logic [data_width-1:0] v;
    logic                  c;
    logic                  top;
    logic                  in_bit;
    logic                  sh_of;
    msb = d_word_op ? 4'd15 : 4'd7;
    xm  = d_x[msb];
    ym  = d_y[msb];
    // adder shared by add, adc, sub, sbb and cmp.
    cin    = (d_func == func_adc || d_func == func_sbb) ? d_iflags[flag_cf] : 1'b0;
    sub_op = (d_func == func_sub || d_func == func_sbb || d_func == func_cmp);
    if (sub_op) begin
      sum = {1'b0, d_x} - {1'b0, d_y} - (data_width + 1)'(cin);
    end else begin
      sum = {1'b0, d_x} + {1'b0, d_y} + (data_width + 1)'(cin);
    end
    rm = sum[msb];

    // shifts one position per count step.
    v      = d_x;
    c      = d_iflags[flag_cf];
    top    = 1'b0;
    in_bit = 1'b0;
    for (int i = 0; i < 32; i++) begin
      if (i < d_y[4:0]) begin
        top = v[msb];
        case (d_func)
          func_rol:           in_bit = top;
          func_ror:           in_bit = v[0];
          func_rcl, func_rcr: in_bit = c;
          func_sar:           in_bit = top;
          default:            in_bit = 1'b0;
        endcase
        // even func codes move left.
        if (!d_func[0]) begin
          c = top;
          v = {v[data_width-2:0], in_bit};
        end else begin
          c = v[0];
          v = v >> 1;
          v[msb] = in_bit;
        end
        if (!d_word_op) begin
          v[15:8] = 8'h00;
        end
      end
    end
    case (d_func)
      func_ror, func_rcr: sh_of = v[msb] ^ v[msb - 4'd1];
      func_shr:           sh_of = xm;
      func_sar:           sh_of = 1'b0;
      default:            sh_of = v[msb] ^ c;
    endcase

    case (d_class)
      class_arith: begin
        n_keep = 1'b0;
        case (d_func)
          func_or, func_and, func_xor: begin
            // logic ops clear the arithmetic flags.
            if (d_func == func_or) begin
              n_result = d_x | d_y;
            end else if (d_func == func_and) begin
              n_result = d_x & d_y;
            end else begin
              n_result = d_x ^ d_y;
            end
            n_cf = 1'b0;
            n_af = 1'b0;
            n_of = 1'b0;
          end
          default: begin
            n_result = d_word_op ? sum[15:0] : {8'd0, sum[7:0]};
            n_cf     = d_word_op ? sum[16] : sum[8];
            n_af     = d_x[4] ^ d_y[4] ^ sum[4];
            // signed overflow, operand signs vs result sign.
            n_of     = sub_op ? (xm != ym) && (rm != xm) : (xm == ym) && (rm != xm);
          end
        endcase
      end
      class_shift: begin
        n_result = v;
        n_cf     = c;
        n_af     = d_iflags[flag_af];
        n_of     = sh_of;
        n_keep   = (d_y[4:0] == 5'd0);
      end
      default: begin
        // move, flags untouched.
        n_result = d_y;
        n_cf     = 1'b0;
        n_af     = 1'b0;
        n_of     = 1'b0;
        n_keep   = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      e_valid <= 1'b0;
    end else begin
      e_valid <= d_valid;
    end
  end

  always_ff @(posedge clk) begin
    e_result  <= n_result;
    e_cf      <= n_cf;
    e_af      <= n_af;
    e_of      <= n_of;
    e_keep    <= n_keep;
    e_word_op <= d_word_op;
    e_iflags  <= d_iflags;
  end

endmodule

/* design/alu_flags.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Flags stage: derives pf, zf and sf and packs the output flag word,
// then pushes the pair into the result queue.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module alu_flags import alu_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  e_valid,
  input  logic [data_width-1:0] e_result,
  input  logic                  e_cf,
  input  logic                  e_af,
  input  logic                  e_of,
  input  logic                  e_keep,
  input  logic                  e_word_op,
  input  logic [data_width-1:0] e_iflags,
  output logic                  q_push,
  output logic [data_width-1:0] f_result,
  output logic [data_width-1:0] f_flags
);

  logic                  pf;
  logic                  zf;
  logic                  sf;
  logic [data_width-1:0] new_flags;

  // parity of the low byte only, as on x86.
  assign pf = ~^e_result[7:0];
  assign zf = e_word_op ? ~|e_result : ~|e_result[7:0];
  assign sf = e_word_op ? e_result[15] : e_result[7];

  always_comb begin
    // control and reserved bits pass from iflags.
    new_flags          = e_iflags;
    new_flags[flag_cf] = e_cf;
    new_flags[flag_pf] = pf;
    new_flags[flag_af] = e_af;
    new_flags[flag_zf] = zf;
    new_flags[flag_sf] = sf;
    new_flags[flag_of] = e_of;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      q_push <= 1'b0;
    end else begin
      q_push <= e_valid;
    end
  end

  always_ff @(posedge clk) begin
    f_result <= e_result;
    f_flags  <= e_keep ? e_iflags : new_flags;
  end

endmodule

/* design/alu_result_queue.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Circular buffer of result and flag word pairs, read back by the slave.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module alu_result_queue import alu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   q_push,
  input  logic [data_width-1:0]  f_result,
  input  logic [data_width-1:0]  f_flags,
  input  logic                   q_pop,
  output logic [data_width-1:0]  q_head_result,
  output logic [data_width-1:0]  q_head_flags,
  output logic [count_width-1:0] q_count
);

  logic [data_width-1:0] res_mem [queue_depth];
  logic [data_width-1:0] flg_mem [queue_depth];
  logic [ptr_width-1:0]  wr_ptr;
  logic [ptr_width-1:0]  rd_ptr;

  always_ff @(posedge clk) begin
    if (q_push) begin
      res_mem[wr_ptr] <= f_result;
      flg_mem[wr_ptr] <= f_flags;
    end
  end

  // pointers wrap at the power-of-two depth.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      q_count <= '0;
    end else begin
      if (q_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (q_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({q_push, q_pop})
        2'b10:   q_count <= q_count + 1'b1;
        2'b01:   q_count <= q_count - 1'b1;
        default: q_count <= q_count;
      endcase
    end
  end

  assign q_head_result = res_mem[rd_ptr];
  assign q_head_flags  = flg_mem[rd_ptr];

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    q_push |-> q_count != count_width'(queue_depth));
  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    q_pop |-> q_count != '0);

endmodule

/* design/alu_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ALU coprocessor top: bus slave, three pipeline stages, result queue.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module alu_top import alu_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cyc,
  input  logic                  stb,
  input  logic                  we,
  input  logic [2:0]            adr,
  input  logic [data_width-1:0] dat_w,
  output logic [data_width-1:0] dat_r,
  output logic                  ack
);

  // slave to decode.
  logic                   issue;
  logic [data_width-1:0]  x;
  logic [data_width-1:0]  y;
  logic [data_width-1:0]  iflags;
  logic [1:0]             op_class;
  logic [2:0]             func;
  logic                   word_op;
  // decode to execute.
  logic                   d_valid;
  logic [data_width-1:0]  d_x;
  logic [data_width-1:0]  d_y;
  logic [data_width-1:0]  d_iflags;
  logic [1:0]             d_class;
  logic [2:0]             d_func;
  logic                   d_word_op;
  // execute to flags.
  logic                   e_valid;
  logic [data_width-1:0]  e_result;
  logic                   e_cf;
  logic                   e_af;
  logic                   e_of;
  logic                   e_keep;
  logic                   e_word_op;
  logic [data_width-1:0]  e_iflags;
  // flags and slave to queue.
  logic                   q_push;
  logic [data_width-1:0]  f_result;
  logic [data_width-1:0]  f_flags;
  logic                   q_pop;
  logic [data_width-1:0]  q_head_result;
  logic [data_width-1:0]  q_head_flags;
  logic [count_width-1:0] q_count;

  alu_wb_regs u_wb_regs (
    .clk, .rst_n, .cyc, .stb, .we, .adr, .dat_w,
    .q_head_result, .q_head_flags, .q_count, .q_push,
    .ack, .dat_r, .issue, .x, .y, .iflags, .op_class, .func, .word_op, .q_pop
  );

  alu_decode u_decode (
    .clk, .rst_n, .issue, .x, .y, .iflags, .op_class, .func, .word_op,
    .d_valid, .d_x, .d_y, .d_iflags, .d_class, .d_func, .d_word_op
  );

  alu_execute u_execute (
    .clk, .rst_n, .d_valid, .d_x, .d_y, .d_iflags, .d_class, .d_func, .d_word_op,
    .e_valid, .e_result, .e_cf, .e_af, .e_of, .e_keep, .e_word_op, .e_iflags
  );

  alu_flags u_flags (
    .clk, .rst_n, .e_valid, .e_result, .e_cf, .e_af, .e_of, .e_keep,
    .e_word_op, .e_iflags, .q_push, .f_result, .f_flags
  );

  alu_result_queue u_result_queue (
    .clk, .rst_n, .q_push, .f_result, .f_flags, .q_pop,
    .q_head_result, .q_head_flags, .q_count
  );

endmodule

/* bench/alu_model.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model of one ALU command, included inside the testbench
// module. Returns the flag word in bits 31:16 and the result in 15:0.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef alu_model_svh
`define alu_model_svh

function automatic logic [31:0] compute_op(
  input logic [15:0] x,
  input logic [15:0] y,
  input logic [15:0] iflags,
  input logic [5:0]  cmd
);
  logic [1:0]  cls;
  logic [2:0]  fn;
  logic [15:0] mask;
  logic [15:0] top_pos;
  logic [15:0] a;
  logic [15:0] b;
  logic [15:0] res;
  logic [15:0] flags;
  logic        cin;
  logic        cf;
  logic        af;
  logic        of;
  logic        msb_bit;
  logic        lsb_bit;
  logic        sa;
  logic        sb;
  logic        sr;
  int          cnt;
  int          total;
  cls     = cmd[1:0];
  fn      = cmd[4:2];
  mask    = cmd[5] ? 16'hffff : 16'h00ff;
  top_pos = cmd[5] ? 16'h8000 : 16'h0080;
  a       = x & mask;
  b       = y & mask;
  cin     = iflags[flag_cf];
  res     = 16'h0000;
  cf      = 1'b0;
  af      = 1'b0;
  of      = 1'b0;
  if (cls == class_shift) begin
    cnt = int'(y[4:0]);
    // zero count is a no-op on x86.
    if (cnt == 0) begin
      return {iflags, a};
    end
    res = a;
    cf  = cin;
    for (int i = 0; i < cnt; i++) begin
      msb_bit = (res & top_pos) != 16'h0;
      lsb_bit = res[0];
      case (fn)
        func_rol: res = ((res << 1) & mask) | 16'(msb_bit);
        func_ror: res = (res >> 1) | (lsb_bit ? top_pos : 16'h0);
        func_rcl: res = ((res << 1) & mask) | 16'(cf);
        func_rcr: res = (res >> 1) | (cf ? top_pos : 16'h0);
        func_shr: res = res >> 1;
        func_sar: res = (res >> 1) | (msb_bit ? top_pos : 16'h0);
        default:  res = (res << 1) & mask;
      endcase
      // odd codes shift right, bit 0 falls into cf.
      cf = fn[0] ? lsb_bit : msb_bit;
    end
    msb_bit = (res & top_pos) != 16'h0;
    case (fn)
      func_ror, func_rcr: of = msb_bit ^ ((res & (top_pos >> 1)) != 16'h0);
      func_shr:           of = (a & top_pos) != 16'h0;
      func_sar:           of = 1'b0;
      default:            of = msb_bit ^ cf;
    endcase
    af = iflags[flag_af];
  end else if (cls == class_arith) begin
    case (fn)
      func_or:  res = a | b;
      func_and: res = a & b;
      func_xor: res = a ^ b;
      func_add, func_adc: begin
        if (fn == func_add) begin
          cin = 1'b0;
        end
        total = int'(a) + int'(b) + int'(cin);
        res   = 16'(total) & mask;
        cf    = total > int'(mask);
        af    = (int'(a[3:0]) + int'(b[3:0]) + int'(cin)) > 15;
      end
      default: begin
        // sub, sbb and cmp, borrow is cf.
        if (fn != func_sbb) begin
          cin = 1'b0;
        end
        total = int'(a) - int'(b) - int'(cin);
        res   = 16'(total) & mask;
        cf    = total < 0;
        af    = int'(a[3:0]) < (int'(b[3:0]) + int'(cin));
      end
    endcase
    sa = (a & top_pos) != 16'h0;
    sb = (b & top_pos) != 16'h0;
    sr = (res & top_pos) != 16'h0;
    if (fn == func_add || fn == func_adc) begin
      of = (sa == sb) && (sr != sa);
    end else if (fn == func_sub || fn == func_sbb || fn == func_cmp) begin
      of = (sa != sb) && (sr != sa);
    end
  end else begin
    // move leaves every flag alone.
    return {iflags, b};
  end
  flags          = iflags;
  flags[flag_cf] = cf;
  flags[flag_pf] = ~^res[7:0];
  flags[flag_af] = af;
  flags[flag_zf] = (res & mask) == 16'h0;
  flags[flag_sf] = (res & top_pos) != 16'h0;
  flags[flag_of] = of;
  return {flags, res};
endfunction

`endif

/* bench/alu_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the ALU coprocessor: random commands over Wishbone,
// results and flags checked against the reference model.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module alu_tb import alu_pkg::*; ();

  localparam int n_arith    = 80;
  localparam int n_shift    = 80;
  localparam int n_move     = 12;
  localparam int n_burst    = 5;
  localparam int total_cmds = n_arith + n_shift + n_move + n_burst;
  localparam int wd_cycles  = 200 * total_cmds + 1000;

  logic        clk;
  logic        rst_n;
  logic        cyc;
  logic        stb;
  logic        we;
  logic [2:0]  adr;
  logic [15:0] dat_w;
  logic [15:0] dat_r;
  logic        ack;

  int          errors;
  int          checks;
  // expected {flags, result} in issue order.
  logic [31:0] expected_q [$];

  `include "alu_model.svh"

  alu_top dut0 (
    .clk, .rst_n, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // bounds the whole run.
  initial begin : watchdog
    repeat (wd_cycles) @(posedge clk);
    $display("timeout: no end of test after %0d cycles", wd_cycles);
    $display("Some tests failed");
    $finish;
  end

  task automatic check(input string name, input logic [15:0] expected,
                       input logic [15:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // drive a new transfer after the edge.
  task automatic start_cycle(input logic [2:0] a, input logic write, input logic [15:0] d);
    @(posedge clk);
    #2;
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = write;
    adr   = a;
    dat_w = d;
  endtask

  task automatic end_cycle();
    @(posedge clk);
    #2;
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  endtask

  // ack sampled mid-cycle away from the edge.
  task automatic wait_ack();
    do begin
      @(posedge clk);
      #1;
    end while (ack !== 1'b1);
  endtask

  task automatic wb_write(input logic [2:0] a, input logic [15:0] d);
    start_cycle(a, 1'b1, d);
    wait_ack();
    end_cycle();
  endtask

  task automatic wb_read(input logic [2:0] a, output logic [15:0] d);
    start_cycle(a, 1'b0, 16'h0000);
    wait_ack();
    d = dat_r;
    end_cycle();
  endtask

  // write that gives up after a number of cycles.
  task automatic try_write(input logic [2:0] a, input logic [15:0] d,
                           input int limit, output bit acked);
    int n;
    acked = 1'b0;
    n     = 0;
    start_cycle(a, 1'b1, d);
    while (!acked && n < limit) begin
      @(posedge clk);
      #1;
      acked = (ack === 1'b1);
      n++;
    end
    end_cycle();
  endtask

  // poll status until n entries are queued.
  task automatic wait_queued(input int n);
    logic [15:0] s;
    s = 16'h0000;
    do begin
      wb_read(reg_status, s);
      if (s > queue_depth) begin
        errors++;
        $display("status reported %0d entries, more than the queue can hold", s);
      end
    end while (s < n);
  endtask

  task automatic load_operands(input logic [15:0] x, input logic [15:0] y,
                               input logic [15:0] f);
    wb_write(reg_x, x);
    wb_write(reg_y, y);
    wb_write(reg_iflags, f);
  endtask

  task automatic issue_cmd(input logic [15:0] x, input logic [15:0] y,
                           input logic [15:0] f, input logic [5:0] cmd);
    load_operands(x, y, f);
    wb_write(reg_cmd, {10'd0, cmd});
    expected_q.push_back(compute_op(x, y, f, cmd));
  endtask

  // read back the head pair and pop it through oflags.
  task automatic drain_one(input string name, output logic [15:0] res,
                           output logic [15:0] flg);
    logic [31:0] exp;
    wait_queued(1);
    exp = expected_q.pop_front();
    wb_read(reg_result, res);
    wb_read(reg_oflags, flg);
    check({name, " result"}, exp[15:0], res);
    check({name, " flags"}, exp[31:16], flg);
  endtask

  task automatic run_op(input logic [15:0] x, input logic [15:0] y,
                        input logic [15:0] f, input logic [5:0] cmd, input string name,
                        output logic [15:0] res, output logic [15:0] flg);
    issue_cmd(x, y, f, cmd);
    drain_one(name, res, flg);
  endtask

  initial begin : main
    logic [15:0] x;
    logic [15:0] y;
    logic [15:0] f;
    logic [15:0] s;
    logic [15:0] res;
    logic [15:0] flg;
    logic [15:0] mask;
    logic [5:0]  cmd;
    logic [2:0]  fn;
    logic [1:0]  cls;
    logic        wop;
    bit          acked;
    void'($urandom(32'h0b3c_e180));
    errors = 0;
    checks = 0;
    rst_n  = 1'b0;
    cyc    = 1'b0;
    stb    = 1'b0;
    we     = 1'b0;
    adr    = 3'd0;
    dat_w  = 16'h0000;
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // empty queue after reset.
    wb_read(reg_status, s);
    check("reset status", 16'h0000, s);
    wb_read(reg_result, s);
    check("empty result", 16'h0000, s);
    wb_read(reg_oflags, s);
    check("empty oflags", 16'h0000, s);
    wb_read(reg_status, s);
    check("status after empty reads", 16'h0000, s);

    // group-1 arithmetic and logic.
    for (int i = 0; i < n_arith; i++) begin
      wop = 1'($urandom_range(0, 1));
      fn  = 3'($urandom_range(0, 7));
      cmd = {wop, fn, class_arith};
      x   = 16'($urandom);
      y   = 16'($urandom);
      f   = 16'($urandom);
      run_op(x, y, f, cmd, $sformatf("group1 func %0d word %0d", fn, wop), res, flg);
    end

    // shifts and rotates with every eighth count forced to zero.
    for (int i = 0; i < n_shift; i++) begin
      wop  = 1'($urandom_range(0, 1));
      fn   = 3'($urandom_range(0, 7));
      cmd  = {wop, fn, class_shift};
      mask = wop ? 16'hffff : 16'h00ff;
      x    = 16'($urandom);
      y    = 16'($urandom);
      f    = 16'($urandom);
      if (i % 8 == 0) begin
        y[4:0] = 5'd0;
      end
      run_op(x, y, f, cmd, $sformatf("shift func %0d word %0d", fn, wop), res, flg);
      if (y[4:0] == 5'd0) begin
        check("shift zero count result", x & mask, res);
        check("shift zero count flags", f, flg);
      end
    end

    // move passes y and leaves the flags untouched.
    for (int i = 0; i < n_move; i++) begin
      wop  = 1'($urandom_range(0, 1));
      cmd  = {wop, 3'd0, class_move};
      mask = wop ? 16'hffff : 16'h00ff;
      x    = 16'($urandom);
      y    = 16'($urandom);
      f    = 16'($urandom);
      run_op(x, y, f, cmd, $sformatf("move word %0d", wop), res, flg);
      check("move result", y & mask, res);
      check("move flags", f, flg);
    end

    // operand and command registers hold the last written values.
    wb_read(reg_x, s);
    check("x readback", x, s);
    wb_read(reg_y, s);
    check("y readback", y, s);
    wb_read(reg_iflags, s);
    check("iflags readback", f, s);
    wb_read(reg_cmd, s);
    check("cmd readback", {10'd0, cmd}, s);

    // four commands fill every credit.
    for (int i = 0; i < n_burst - 1; i++) begin
      cls = 2'($urandom_range(0, 1));
      cmd = {1'($urandom_range(0, 1)), 3'($urandom_range(0, 7)), cls};
      issue_cmd(16'($urandom), 16'($urandom), 16'($urandom), cmd);
    end
    cls = 2'($urandom_range(0, 1));
    cmd = {1'($urandom_range(0, 1)), 3'($urandom_range(0, 7)), cls};
    x   = 16'($urandom);
    y   = 16'($urandom);
    f   = 16'($urandom);
    load_operands(x, y, f);
    // fifth cmd must stall with the queue full.
    try_write(reg_cmd, {10'd0, cmd}, 40, acked);
    if (acked) begin
      errors++;
      $display("fifth cmd write was acked while four results were outstanding");
    end
    wait_queued(4);
    wb_read(reg_status, s);
    check("burst status full", 16'd4, s);
    drain_one("burst 0", res, flg);
    // one pop frees a credit.
    wb_write(reg_cmd, {10'd0, cmd});
    expected_q.push_back(compute_op(x, y, f, cmd));
    for (int i = 1; i < n_burst; i++) begin
      drain_one($sformatf("burst %0d", i), res, flg);
    end
    wb_read(reg_status, s);
    check("status after burst", 16'h0000, s);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+bench
design/alu_pkg.sv
design/alu_wb_regs.sv
design/alu_decode.sv
design/alu_execute.sv
design/alu_flags.sv
design/alu_result_queue.sv
design/alu_top.sv
bench/alu_tb.sv
